/* design/sched_pkg.sv */
package sched_pkg;

    // warp-control opcodes carried on ctl_op
    typedef enum logic [1:0] {
        CTL_TMC    = 2'd0,
        CTL_WSPAWN = 2'd1,
        CTL_BAR    = 2'd2
    } ctl_op_t;

    // four-phase handshake states of the dispatch side
    typedef enum logic [1:0] {
        DS_IDLE    = 2'd0,
        DS_REQ     = 2'd1,
        DS_RELEASE = 2'd2
    } dispatch_state_t;

    // pc advance per issued instruction
    localparam logic [31:0] PC_STEP = 32'd4;

endpackage

/* design/warp_table.sv */
`timescale 1ns/100ps

module warp_table #(
    parameter NUM_WARPS   = 4,
    parameter NUM_THREADS = 4,
    parameter PC_BITS     = 32,
    parameter START_PC    = 32'h80000000,
    localparam NW_BITS    = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  unlock_valid,
    input  logic [NW_BITS-1:0]                    unlock_wid,
    input  logic                                  br_valid,
    input  logic [NW_BITS-1:0]                    br_wid,
    input  logic                                  br_taken,
    input  logic [PC_BITS-1:0]                    br_dest,
    input  logic                                  ctl_valid,
    input  sched_pkg::ctl_op_t                    ctl_op,
    input  logic [NW_BITS-1:0]                    ctl_wid,
    input  logic [NUM_THREADS-1:0]                ctl_tmask,
    input  logic [NUM_WARPS-1:0]                  ctl_wmask,
    input  logic [PC_BITS-1:0]                    ctl_pc,
    input  logic                                  bar_release_valid,
    input  logic [NUM_WARPS-1:0]                  bar_release_mask,
    input  logic                                  issue_valid,
    input  logic [NW_BITS-1:0]                    issue_wid,
    output logic [NUM_WARPS-1:0]                  ready_mask,
    output logic [NUM_WARPS-1:0][PC_BITS-1:0]     pc_table,
    output logic [NUM_WARPS-1:0][NUM_THREADS-1:0] tmask_table,
    output logic                                  active_any
);
    import sched_pkg::*;

    logic [NUM_WARPS-1:0]                  active;
    logic [NUM_WARPS-1:0]                  active_n;
    logic [NUM_WARPS-1:0]                  stalled;
    logic [NUM_WARPS-1:0]                  stalled_n;
    logic [NUM_WARPS-1:0][PC_BITS-1:0]     pcs_n;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0] tmasks_n;

    always_comb begin
        active_n  = active;
        stalled_n = stalled;
        pcs_n     = pc_table;
        tmasks_n  = tmask_table;

        if (unlock_valid) begin
            stalled_n[unlock_wid] = 1'b0;
        end

        if (br_valid) begin
            if (br_taken) begin
                pcs_n[br_wid] = br_dest;
            end
            stalled_n[br_wid] = 1'b0;
        end

        if (ctl_valid) begin
            case (ctl_op)
                CTL_TMC: begin
                    // an empty mask retires the warp
                    tmasks_n[ctl_wid]  = ctl_tmask;
                    active_n[ctl_wid]  = (ctl_tmask != '0);
                    stalled_n[ctl_wid] = 1'b0;
                end
                CTL_WSPAWN: begin
                    for (int i = 0; i < NUM_WARPS; i++) begin
                        if (ctl_wmask[i]) begin
                            active_n[i] = 1'b1;
                            pcs_n[i]    = ctl_pc;
                            tmasks_n[i] = NUM_THREADS'(1);
                        end
                    end
                    stalled_n[ctl_wid] = 1'b0;
                end
                default: begin
                    // barrier, caller waits for the release mask
                end
            endcase
        end

        if (bar_release_valid) begin
            stalled_n = stalled_n & ~bar_release_mask;
        end

        // issue wins, so the warp is stalled before the next pick
        if (issue_valid) begin
            stalled_n[issue_wid] = 1'b1;
            pcs_n[issue_wid]     = pc_table[issue_wid] + PC_BITS'(PC_STEP);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active         <= '0;
            stalled        <= '0;
            pc_table       <= '0;
            tmask_table    <= '0;
            // warp 0 starts alone on thread 0
            active[0]      <= 1'b1;
            pc_table[0]    <= PC_BITS'(START_PC);
            tmask_table[0] <= NUM_THREADS'(1);
        end else begin
            active      <= active_n;
            stalled     <= stalled_n;
            pc_table    <= pcs_n;
            tmask_table <= tmasks_n;
        end
    end

    assign ready_mask = active & ~stalled;
    assign active_any = |active;

endmodule

/* design/barrier_unit.sv */
`timescale 1ns/100ps

module barrier_unit #(
    parameter NUM_WARPS    = 4,
    parameter NUM_BARRIERS = 2,
    localparam NW_BITS     = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1,
    localparam NB_BITS     = (NUM_BARRIERS > 1) ? $clog2(NUM_BARRIERS) : 1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ctl_valid,
    input  sched_pkg::ctl_op_t   ctl_op,
    input  logic [NW_BITS-1:0]   ctl_wid,
    input  logic [NB_BITS-1:0]   ctl_bar_id,
    input  logic [NW_BITS-1:0]   ctl_bar_size_m1,
    output logic                 bar_release_valid,
    output logic [NUM_WARPS-1:0] bar_release_mask
);
    import sched_pkg::*;

    logic [NUM_BARRIERS-1:0][NW_BITS-1:0]   bar_cnt;
    logic [NUM_BARRIERS-1:0][NUM_WARPS-1:0] bar_wait;
    logic [NUM_WARPS-1:0]                   arrived_mask;
    logic                                   bar_op;
    logic                                   bar_done;

    // waiting warps of the addressed barrier plus the caller
    always_comb begin
        arrived_mask          = bar_wait[ctl_bar_id];
        arrived_mask[ctl_wid] = 1'b1;
    end

    assign bar_op   = ctl_valid && (ctl_op == CTL_BAR);
    assign bar_done = bar_op && (bar_cnt[ctl_bar_id] == ctl_bar_size_m1);

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_cnt           <= '0;
            bar_wait          <= '0;
            bar_release_valid <= 1'b0;
        end else begin
            bar_release_valid <= bar_done;
            if (bar_done) begin
                bar_cnt[ctl_bar_id]  <= '0;
                bar_wait[ctl_bar_id] <= '0;
            end else if (bar_op) begin
                bar_cnt[ctl_bar_id]  <= bar_cnt[ctl_bar_id] + NW_BITS'(1);
                bar_wait[ctl_bar_id] <= arrived_mask;
            end
        end
    end

    // release mask only means something while bar_release_valid is high
    always_ff @(posedge clk) begin
        if (bar_done) begin
            bar_release_mask <= arrived_mask;
        end
    end

endmodule

/* design/dispatch_fsm.sv */
`timescale 1ns/100ps

module dispatch_fsm #(
    parameter NUM_WARPS   = 4,
    parameter NUM_THREADS = 4,
    parameter PC_BITS     = 32,
    localparam NW_BITS    = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [NUM_WARPS-1:0]                  ready_mask,
    input  logic [NUM_WARPS-1:0][PC_BITS-1:0]     pc_table,
    input  logic [NUM_WARPS-1:0][NUM_THREADS-1:0] tmask_table,
    input  logic                                  sched_ack,
    output logic                                  issue_valid,
    output logic [NW_BITS-1:0]                    issue_wid,
    output logic                                  sched_req,
    output logic [NW_BITS-1:0]                    sched_wid,
    output logic [PC_BITS-1:0]                    sched_pc,
    output logic [NUM_THREADS-1:0]                sched_tmask
);
    import sched_pkg::*;

    dispatch_state_t    state;
    dispatch_state_t    state_n;
    logic [NW_BITS-1:0] pick_wid;

    // lowest ready index wins
    always_comb begin
        pick_wid = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_mask[i]) begin
                pick_wid = NW_BITS'(i);
            end
        end
    end

    assign issue_valid = (state == DS_IDLE) && (ready_mask != '0);
    assign issue_wid   = pick_wid;

    always_comb begin
        state_n = state;
        case (state)
            DS_IDLE: begin
                if (issue_valid) begin
                    state_n = DS_REQ;
                end
            end
            DS_REQ: begin
                // no ack means we simply keep requesting
                if (sched_ack) begin
                    state_n = DS_RELEASE;
                end
            end
            DS_RELEASE: begin
                if (!sched_ack) begin
                    state_n = DS_IDLE;
                end
            end
            default: begin
                state_n = DS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DS_IDLE;
        end else begin
            state <= state_n;
        end
    end

    // held stable from latch until the handshake completes
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            sched_wid   <= pick_wid;
            sched_pc    <= pc_table[pick_wid];
            sched_tmask <= tmask_table[pick_wid];
        end
    end

    assign sched_req = (state == DS_REQ);

endmodule

/* design/pending_counter.sv */
`timescale 1ns/100ps

module pending_counter #(
    parameter PENDING_BITS = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic issue_valid,
    input  logic commit_valid,
    input  logic active_any,
    output logic busy
);

    logic [PENDING_BITS-1:0] pending;

    // instructions issued but not yet committed
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else if (issue_valid && !commit_valid) begin
            pending <= pending + PENDING_BITS'(1);
        end else if (commit_valid && !issue_valid) begin
            pending <= pending - PENDING_BITS'(1);
        end
    end

    // one cycle behind its condition
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= active_any || (pending != '0);
        end
    end

endmodule

/* design/warp_scheduler.sv */
`timescale 1ns/100ps

module warp_scheduler #(
    parameter NUM_WARPS    = 4,
    parameter NUM_THREADS  = 4,
    parameter NUM_BARRIERS = 2,
    parameter PC_BITS      = 32,
    parameter PENDING_BITS = 4,
    parameter START_PC     = 32'h80000000,
    localparam NW_BITS     = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1,
    localparam NB_BITS     = (NUM_BARRIERS > 1) ? $clog2(NUM_BARRIERS) : 1
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   unlock_valid,
    input  logic [NW_BITS-1:0]     unlock_wid,
    input  logic                   br_valid,
    input  logic [NW_BITS-1:0]     br_wid,
    input  logic                   br_taken,
    input  logic [PC_BITS-1:0]     br_dest,
    input  logic                   ctl_valid,
    input  sched_pkg::ctl_op_t     ctl_op,
    input  logic [NW_BITS-1:0]     ctl_wid,
    input  logic [NUM_THREADS-1:0] ctl_tmask,
    input  logic [NUM_WARPS-1:0]   ctl_wmask,
    input  logic [PC_BITS-1:0]     ctl_pc,
    input  logic [NB_BITS-1:0]     ctl_bar_id,
    input  logic [NW_BITS-1:0]     ctl_bar_size_m1,
    input  logic                   commit_valid,
    input  logic                   sched_ack,
    output logic                   sched_req,
    output logic [NW_BITS-1:0]     sched_wid,
    output logic [PC_BITS-1:0]     sched_pc,
    output logic [NUM_THREADS-1:0] sched_tmask,
    output logic                   busy
);

    logic                                  issue_valid;
    logic [NW_BITS-1:0]                    issue_wid;
    logic [NUM_WARPS-1:0]                  ready_mask;
    logic [NUM_WARPS-1:0][PC_BITS-1:0]     pc_table;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0] tmask_table;
    logic                                  bar_release_valid;
    logic [NUM_WARPS-1:0]                  bar_release_mask;
    logic                                  active_any;

    warp_table #(
        .NUM_WARPS   (NUM_WARPS),
        .NUM_THREADS (NUM_THREADS),
        .PC_BITS     (PC_BITS),
        .START_PC    (START_PC)
    ) warp_table_i (
        .clk               (clk),
        .reset             (reset),
        .unlock_valid      (unlock_valid),
        .unlock_wid        (unlock_wid),
        .br_valid          (br_valid),
        .br_wid            (br_wid),
        .br_taken          (br_taken),
        .br_dest           (br_dest),
        .ctl_valid         (ctl_valid),
        .ctl_op            (ctl_op),
        .ctl_wid           (ctl_wid),
        .ctl_tmask         (ctl_tmask),
        .ctl_wmask         (ctl_wmask),
        .ctl_pc            (ctl_pc),
        .bar_release_valid (bar_release_valid),
        .bar_release_mask  (bar_release_mask),
        .issue_valid       (issue_valid),
        .issue_wid         (issue_wid),
        .ready_mask        (ready_mask),
        .pc_table          (pc_table),
        .tmask_table       (tmask_table),
        .active_any        (active_any)
    );

    barrier_unit #(
        .NUM_WARPS    (NUM_WARPS),
        .NUM_BARRIERS (NUM_BARRIERS)
    ) barrier_unit_i (
        .clk               (clk),
        .reset             (reset),
        .ctl_valid         (ctl_valid),
        .ctl_op            (ctl_op),
        .ctl_wid           (ctl_wid),
        .ctl_bar_id        (ctl_bar_id),
        .ctl_bar_size_m1   (ctl_bar_size_m1),
        .bar_release_valid (bar_release_valid),
        .bar_release_mask  (bar_release_mask)
    );

    dispatch_fsm #(
        .NUM_WARPS   (NUM_WARPS),
        .NUM_THREADS (NUM_THREADS),
        .PC_BITS     (PC_BITS)
    ) dispatch_fsm_i (
        .clk         (clk),
        .reset       (reset),
        .ready_mask  (ready_mask),
        .pc_table    (pc_table),
        .tmask_table (tmask_table),
        .sched_ack   (sched_ack),
        .issue_valid (issue_valid),
        .issue_wid   (issue_wid),
        .sched_req   (sched_req),
        .sched_wid   (sched_wid),
        .sched_pc    (sched_pc),
        .sched_tmask (sched_tmask)
    );

    pending_counter #(
        .PENDING_BITS (PENDING_BITS)
    ) pending_counter_i (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .commit_valid (commit_valid),
        .active_any   (active_any),
        .busy         (busy)
    );

endmodule

/* verification/tb_warp_scheduler.sv */
`timescale 1ns/100ps

module tb_warp_scheduler;
    import sched_pkg::*;

    localparam int NUM_WARPS        = 4;
    localparam int NUM_THREADS      = 4;
    localparam int NUM_BARRIERS     = 2;
    localparam int PC_BITS          = 32;
    localparam int PENDING_BITS     = 4;
    localparam logic [31:0] START_PC = 32'h8000_0000;
    localparam int NW_BITS          = $clog2(NUM_WARPS);
    localparam int NB_BITS          = $clog2(NUM_BARRIERS);

    localparam logic [31:0] BR_DEST  = 32'h8000_1000;
    localparam logic [31:0] SPAWN_PC = 32'h8000_2000;
    localparam int DISPATCH_TIMEOUT  = 60;
    localparam int QUIET_CYCLES      = 24;
    localparam int ACK_TIMEOUT       = 20;
    localparam int IDLE_LIMIT        = 1000;
    localparam int MAX_ROWS          = 24;

    typedef enum logic [2:0] {R_NONE, R_UNLOCK, R_BRANCH, R_CTL, R_COMMIT} row_op_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   unlock_valid;
    logic [NW_BITS-1:0]     unlock_wid;
    logic                   br_valid;
    logic [NW_BITS-1:0]     br_wid;
    logic                   br_taken;
    logic [PC_BITS-1:0]     br_dest;
    logic                   ctl_valid;
    ctl_op_t                ctl_op;
    logic [NW_BITS-1:0]     ctl_wid;
    logic [NUM_THREADS-1:0] ctl_tmask;
    logic [NUM_WARPS-1:0]   ctl_wmask;
    logic [PC_BITS-1:0]     ctl_pc;
    logic [NB_BITS-1:0]     ctl_bar_id;
    logic [NW_BITS-1:0]     ctl_bar_size_m1;
    logic                   commit_valid;
    logic                   sched_ack;
    logic                   sched_req;
    logic [NW_BITS-1:0]     sched_wid;
    logic [PC_BITS-1:0]     sched_pc;
    logic [NUM_THREADS-1:0] sched_tmask;
    logic                   busy;

    // stimulus table, one entry per row
    row_op_t                t_op   [MAX_ROWS];
    logic [NW_BITS-1:0]     t_wid  [MAX_ROWS];
    ctl_op_t                t_cop  [MAX_ROWS];
    logic [NUM_THREADS-1:0] t_mask [MAX_ROWS];
    logic [PC_BITS-1:0]     t_addr [MAX_ROWS];
    logic [NB_BITS-1:0]     t_bar  [MAX_ROWS];
    int                     t_aux  [MAX_ROWS];
    bit                     t_disp [MAX_ROWS];
    logic [NW_BITS-1:0]     t_ewid [MAX_ROWS];
    logic [PC_BITS-1:0]     t_epc  [MAX_ROWS];
    logic [NUM_THREADS-1:0] t_etm  [MAX_ROWS];
    int                     t_busy [MAX_ROWS];
    int                     num_rows = 0;
    int                     errors = 0;
    int                     rows_failed = 0;

    // dispatches seen by the responder
    logic [NW_BITS-1:0]     q_wid[$];
    logic [PC_BITS-1:0]     q_pc[$];
    logic [NUM_THREADS-1:0] q_tmask[$];

    always #20 clk = ~clk;

    warp_scheduler #(
        .NUM_WARPS    (NUM_WARPS),
        .NUM_THREADS  (NUM_THREADS),
        .NUM_BARRIERS (NUM_BARRIERS),
        .PC_BITS      (PC_BITS),
        .PENDING_BITS (PENDING_BITS),
        .START_PC     (START_PC)
    ) warp_scheduler_i (
        .clk             (clk),
        .reset           (reset),
        .unlock_valid    (unlock_valid),
        .unlock_wid      (unlock_wid),
        .br_valid        (br_valid),
        .br_wid          (br_wid),
        .br_taken        (br_taken),
        .br_dest         (br_dest),
        .ctl_valid       (ctl_valid),
        .ctl_op          (ctl_op),
        .ctl_wid         (ctl_wid),
        .ctl_tmask       (ctl_tmask),
        .ctl_wmask       (ctl_wmask),
        .ctl_pc          (ctl_pc),
        .ctl_bar_id      (ctl_bar_id),
        .ctl_bar_size_m1 (ctl_bar_size_m1),
        .commit_valid    (commit_valid),
        .sched_ack       (sched_ack),
        .sched_req       (sched_req),
        .sched_wid       (sched_wid),
        .sched_pc        (sched_pc),
        .sched_tmask     (sched_tmask),
        .busy            (busy)
    );

    task automatic check_wid(input string tag, input logic [NW_BITS-1:0] got,
                             input logic [NW_BITS-1:0] exp);
        if (got !== exp) begin
            $display("ERR sched_wid (%s): got %h, expected %h", tag, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input string tag, input logic [PC_BITS-1:0] got,
                            input logic [PC_BITS-1:0] exp);
        if (got !== exp) begin
            $display("ERR sched_pc (%s): got %h, expected %h", tag, got, exp);
            errors++;
        end
    endtask

    task automatic check_tmask(input string tag, input logic [NUM_THREADS-1:0] got,
                               input logic [NUM_THREADS-1:0] exp);
        if (got !== exp) begin
            $display("ERR sched_tmask (%s): got %h, expected %h", tag, got, exp);
            errors++;
        end
    endtask

    task automatic check_busy(input string tag, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR busy (%s): got %h, expected %h", tag, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic add_row(input row_op_t op, input logic [NW_BITS-1:0] wid,
                           input ctl_op_t cop, input logic [NUM_THREADS-1:0] mask,
                           input logic [PC_BITS-1:0] addr, input logic [NB_BITS-1:0] bar,
                           input int aux, input bit disp, input logic [NW_BITS-1:0] ewid,
                           input logic [PC_BITS-1:0] epc, input logic [NUM_THREADS-1:0] etm,
                           input int busy_exp);
        t_op[num_rows]   = op;
        t_wid[num_rows]  = wid;
        t_cop[num_rows]  = cop;
        t_mask[num_rows] = mask;
        t_addr[num_rows] = addr;
        t_bar[num_rows]  = bar;
        t_aux[num_rows]  = aux;
        t_disp[num_rows] = disp;
        t_ewid[num_rows] = ewid;
        t_epc[num_rows]  = epc;
        t_etm[num_rows]  = etm;
        t_busy[num_rows] = busy_exp;
        num_rows++;
    endtask

    // one-cycle pulse, commits repeat for t_aux cycles
    task automatic apply_op(input int r);
        @(posedge clk);
        case (t_op[r])
            R_UNLOCK: begin
                unlock_valid <= 1'b1;
                unlock_wid   <= t_wid[r];
            end
            R_BRANCH: begin
                br_valid <= 1'b1;
                br_wid   <= t_wid[r];
                br_taken <= t_mask[r][0];
                br_dest  <= t_addr[r];
            end
            R_CTL: begin
                ctl_valid       <= 1'b1;
                ctl_op          <= t_cop[r];
                ctl_wid         <= t_wid[r];
                ctl_tmask       <= t_mask[r];
                ctl_wmask       <= t_mask[r];
                ctl_pc          <= t_addr[r];
                ctl_bar_id      <= t_bar[r];
                ctl_bar_size_m1 <= t_aux[r][NW_BITS-1:0];
            end
            R_COMMIT: begin
                commit_valid <= 1'b1;
                repeat (t_aux[r] - 1) @(posedge clk);
            end
            default: begin
            end
        endcase
        @(posedge clk);
        unlock_valid <= 1'b0;
        br_valid     <= 1'b0;
        ctl_valid    <= 1'b0;
        commit_valid <= 1'b0;
    endtask

    // downstream side of the four-phase handshake
    initial begin : responder
        int                     idle;
        int                     wait_n;
        int                     delay;
        logic [NW_BITS-1:0]     cap_wid;
        logic [PC_BITS-1:0]     cap_pc;
        logic [NUM_THREADS-1:0] cap_tmask;
        void'($urandom(32'h7147));
        forever begin
            @(negedge clk);
            idle = 0;
            while (sched_req !== 1'b1 && idle < IDLE_LIMIT) begin
                @(negedge clk);
                idle++;
            end
            if (sched_req !== 1'b1) begin
                abort_run("responder saw no request for too long");
            end
            cap_wid   = sched_wid;
            cap_pc    = sched_pc;
            cap_tmask = sched_tmask;
            q_wid.push_back(cap_wid);
            q_pc.push_back(cap_pc);
            q_tmask.push_back(cap_tmask);
            delay = int'($urandom % 4);
            repeat (delay) @(negedge clk);
            // data has to stay put while req is up
            check_wid("held", sched_wid, cap_wid);
            check_pc("held", sched_pc, cap_pc);
            check_tmask("held", sched_tmask, cap_tmask);
            @(posedge clk);
            sched_ack <= 1'b1;
            @(negedge clk);
            wait_n = 0;
            while (sched_req === 1'b1 && wait_n < ACK_TIMEOUT) begin
                @(negedge clk);
                wait_n++;
            end
            if (sched_req === 1'b1) begin
                abort_run("sched_req stayed high after ack");
            end
            @(posedge clk);
            sched_ack <= 1'b0;
        end
    end

    initial begin : main
        int          r;
        int          n;
        int          err_before;
        string       tag;
        reset           = 1'b1;
        unlock_valid    = 1'b0;
        unlock_wid      = '0;
        br_valid        = 1'b0;
        br_wid          = '0;
        br_taken        = 1'b0;
        br_dest         = '0;
        ctl_valid       = 1'b0;
        ctl_op          = CTL_TMC;
        ctl_wid         = '0;
        ctl_tmask       = '0;
        ctl_wmask       = '0;
        ctl_pc          = '0;
        ctl_bar_id      = '0;
        ctl_bar_size_m1 = '0;
        commit_valid    = 1'b0;
        sched_ack       = 1'b0;

        // op, wid, ctl op, mask, addr, bar, aux, then expected dispatch and busy
        add_row(R_NONE, 2'd0, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b1, 2'd0, START_PC, 4'b0001, 1);
        add_row(R_UNLOCK, 2'd0, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b1, 2'd0, START_PC + PC_STEP, 4'b0001, -1);
        add_row(R_NONE, 2'd0, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b0, 2'd0, 32'h0, 4'b0000, -1);
        add_row(R_BRANCH, 2'd0, CTL_TMC, 4'b0001, BR_DEST, 1'b0, 0,
                1'b1, 2'd0, BR_DEST, 4'b0001, -1);
        add_row(R_BRANCH, 2'd0, CTL_TMC, 4'b0000, BR_DEST, 1'b0, 0,
                1'b1, 2'd0, BR_DEST + PC_STEP, 4'b0001, -1);
        // spawn unlocks warp 0 too, so it goes first
        add_row(R_CTL, 2'd0, CTL_WSPAWN, 4'b0110, SPAWN_PC, 1'b0, 0,
                1'b1, 2'd0, BR_DEST + PC_STEP * 32'd2, 4'b0001, -1);
        add_row(R_NONE, 2'd0, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b1, 2'd1, SPAWN_PC, 4'b0001, -1);
        add_row(R_NONE, 2'd0, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b1, 2'd2, SPAWN_PC, 4'b0001, -1);
        add_row(R_CTL, 2'd1, CTL_TMC, 4'b1011, 32'h0, 1'b0, 0,
                1'b1, 2'd1, SPAWN_PC + PC_STEP, 4'b1011, -1);
        add_row(R_CTL, 2'd2, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b0, 2'd0, 32'h0, 4'b0000, -1);
        add_row(R_UNLOCK, 2'd2, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b0, 2'd0, 32'h0, 4'b0000, -1);
        add_row(R_CTL, 2'd0, CTL_BAR, 4'b0000, 32'h0, 1'b0, 1,
                1'b0, 2'd0, 32'h0, 4'b0000, -1);
        add_row(R_CTL, 2'd1, CTL_BAR, 4'b0000, 32'h0, 1'b0, 1,
                1'b1, 2'd0, BR_DEST + PC_STEP * 32'd3, 4'b0001, -1);
        add_row(R_NONE, 2'd0, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b1, 2'd1, SPAWN_PC + PC_STEP * 32'd2, 4'b1011, -1);
        add_row(R_CTL, 2'd0, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b0, 2'd0, 32'h0, 4'b0000, -1);
        add_row(R_CTL, 2'd1, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b0, 2'd0, 32'h0, 4'b0000, 1);
        // ten dispatches so far, keep one pending
        add_row(R_COMMIT, 2'd0, CTL_TMC, 4'b0000, 32'h0, 1'b0, 9,
                1'b0, 2'd0, 32'h0, 4'b0000, 1);
        add_row(R_COMMIT, 2'd0, CTL_TMC, 4'b0000, 32'h0, 1'b0, 1,
                1'b0, 2'd0, 32'h0, 4'b0000, 0);
        add_row(R_NONE, 2'd0, CTL_TMC, 4'b0000, 32'h0, 1'b0, 0,
                1'b0, 2'd0, 32'h0, 4'b0000, 0);

        repeat (15) @(posedge clk);
        @(negedge clk);
        if (sched_req !== 1'b0) begin
            $display("sched_req was not low during reset");
            errors++;
        end
        check_busy("reset", busy, 1'b0);
        @(posedge clk);
        reset <= 1'b0;

        for (r = 0; r < num_rows; r++) begin
            err_before = errors;
            tag = $sformatf("row %0d", r);
            apply_op(r);
            if (t_disp[r]) begin
                n = 0;
                while (q_wid.size() == 0 && n < DISPATCH_TIMEOUT) begin
                    @(posedge clk);
                    n++;
                end
                if (q_wid.size() == 0) begin
                    $display("%s: no dispatch within %0d cycles", tag, DISPATCH_TIMEOUT);
                    errors++;
                end else begin
                    check_wid(tag, q_wid.pop_front(), t_ewid[r]);
                    check_pc(tag, q_pc.pop_front(), t_epc[r]);
                    check_tmask(tag, q_tmask.pop_front(), t_etm[r]);
                end
            end else begin
                repeat (QUIET_CYCLES) @(posedge clk);
                if (q_wid.size() != 0) begin
                    $display("%s: warp %0d was dispatched unexpectedly", tag, q_wid[0]);
                    errors++;
                    q_wid.delete();
                    q_pc.delete();
                    q_tmask.delete();
                end
            end
            @(negedge clk);
            if (t_busy[r] >= 0) begin
                check_busy(tag, busy, t_busy[r][0]);
            end
            if (errors == err_before) begin
                $display("%s ok", tag);
            end else begin
                $display("%s failed", tag);
                rows_failed++;
            end
        end

        if (q_wid.size() != 0) begin
            $display("dispatch left over after the last row");
            errors++;
        end
        $display("rows %0d, failed %0d, errors %0d", num_rows, rows_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tb.f */
design/sched_pkg.sv
design/warp_table.sv
design/barrier_unit.sv
design/dispatch_fsm.sv
design/pending_counter.sv
design/warp_scheduler.sv
verification/tb_warp_scheduler.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_warp_scheduler
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
